//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = icache_tb
FILELIST   = icache_sys.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Testbench failed
PASS_MSG   = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/icache_tb.sv
`default_nettype none

`include "icache_defs.svh"

module icache_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 10;
	localparam int WORDS = 4 * `LINE_MEM_DEPTH;
	localparam int LOAD_W = $clog2(`LINE_MEM_DEPTH) + 2;
	localparam int SETS = `ICACHE_SETS;

	// cycle budget of each test.
	localparam int RESET_CYCLES = 4;
	localparam int SEQ_CYCLES = 512;
	localparam int RAND_CYCLES = 600;
	localparam int STALL_CYCLES = 400;
	localparam int FLUSH_CYCLES = 200;
	localparam int RELOAD_FETCHES = 300;
	localparam int TOTAL_CYCLES = RESET_CYCLES + WORDS + SEQ_CYCLES + 1 + RAND_CYCLES
		+ STALL_CYCLES + 5 + FLUSH_CYCLES + 1 + WORDS + 1 + RELOAD_FETCHES + 11;
	localparam int MARGIN = 500;

	typedef struct packed {
		logic              rst;
		logic              valid;
		icache_pkg::addr_t addr;
		logic              flush;
		logic              ready;
		logic              inv;
		logic              load_en;
		logic [LOAD_W-1:0] load_addr;
		icache_pkg::inst_t load_data;
	} stim_t;

	logic              clk;
	logic              rst;
	logic              fetch_valid;
	icache_pkg::addr_t fetch_addr;
	logic              flush;
	logic              out_ready;
	logic              invalidate;
	logic              load_en;
	logic [LOAD_W-1:0] load_addr;
	icache_pkg::inst_t load_data;
	icache_pkg::inst_t inst;
	logic              inst_hit;
	logic              inst_valid;

	// reference model state.
	icache_pkg::inst_t mem_model [WORDS];
	icache_pkg::tag_t  tag_model [4][SETS];
	logic              valid_model [4][SETS];
	int                victim_model;
	logic              exp_valid;
	logic              exp_hit;
	icache_pkg::inst_t exp_inst;
	stim_t             cur;

	logic [31:0]       rng_state;
	logic [51:0]       upper_pool [4];
	string             test_name;
	int                test_errors;
	int                tests_passed;
	int                tests_failed;
	int                total_errors;

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	icache_top icache_top_i (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_addr (fetch_addr),
		.flush      (flush),
		.out_ready  (out_ready),
		.invalidate (invalidate),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.inst       (inst),
		.inst_hit   (inst_hit),
		.inst_valid (inst_valid)
	);

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper bits from a small pool so tags alias across sets.
	function automatic icache_pkg::addr_t random_addr();
		logic [31:0] r;
		r = next_rand();
		return {upper_pool[r[31:30]], r[25:16], 2'b00};
	endfunction

	function automatic stim_t idle_stim();
		stim_t s;
		s = '0;
		s.ready = 1'b1;
		return s;
	endfunction

	task automatic clear_valid_model();
		for (int w = 0; w < 4; w++) begin
			for (int i = 0; i < SETS; i++) begin
				valid_model[w][i] = 1'b0;
			end
		end
	endtask

	// effect of one clock edge on the model given the inputs applied before it.
	task automatic model_edge();
		icache_pkg::tag_t tag;
		int               set_idx;
		int               hit_way;
		if (cur.rst) begin
			clear_valid_model();
			victim_model = 0;
			exp_valid = 1'b0;
			exp_hit = 1'b0;
		end else begin
			if (cur.ready) begin
				if (cur.flush) begin
					exp_valid = 1'b0;
					exp_hit = 1'b0;
				end else if (cur.valid) begin
					tag = cur.addr[63:10];
					set_idx = int'(cur.addr[9:4]);
					hit_way = -1;
					for (int w = 0; w < 4; w++) begin
						if (valid_model[w][set_idx] && tag_model[w][set_idx] == tag) begin
							hit_way = w;
						end
					end
					exp_valid = 1'b1;
					exp_hit = (hit_way >= 0);
					exp_inst = mem_model[cur.addr[11:2]];
					if (hit_way < 0) begin
						tag_model[victim_model][set_idx] = tag;
						valid_model[victim_model][set_idx] = 1'b1;
					end
				end else begin
					exp_valid = 1'b0;
					exp_hit = 1'b0;
				end
				if (!cur.flush) begin
					victim_model = (victim_model + 1) % 4;
				end
			end
			// invalidate wins over a fill on the same edge.
			if (cur.inv) begin
				clear_valid_model();
			end
			if (cur.load_en) begin
				mem_model[cur.load_addr] = cur.load_data;
			end
		end
	endtask

	task automatic report_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic check_outputs();
		if (inst_valid !== exp_valid) begin
			report_value("inst_valid", {31'b0, exp_valid}, {31'b0, inst_valid});
		end
		if (inst_hit !== exp_hit) begin
			report_value("inst_hit", {31'b0, exp_hit}, {31'b0, inst_hit});
		end
		if (exp_valid && inst !== exp_inst) begin
			report_value("inst", exp_inst, inst);
		end
	endtask

	// update the model at the edge, drive the next inputs, then check mid-cycle.
	task automatic run_cycle(input stim_t s);
		@(posedge clk);
		model_edge();
		rst <= s.rst;
		fetch_valid <= s.valid;
		fetch_addr <= s.addr;
		flush <= s.flush;
		out_ready <= s.ready;
		invalidate <= s.inv;
		load_en <= s.load_en;
		load_addr <= s.load_addr;
		load_data <= s.load_data;
		cur = s;
		@(negedge clk);
		check_outputs();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("test %s: ok", test_name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	task automatic apply_reset();
		stim_t s;
		s = idle_stim();
		s.rst = 1'b1;
		repeat (RESET_CYCLES) run_cycle(s);
	endtask

	task automatic load_memory();
		stim_t s;
		for (int i = 0; i < WORDS; i++) begin
			s = idle_stim();
			s.load_en = 1'b1;
			s.load_addr = LOAD_W'(i);
			s.load_data = next_rand();
			run_cycle(s);
		end
	endtask

	task automatic sequential_test();
		stim_t s;
		start_test("sequential");
		apply_reset();
		load_memory();
		for (int i = 0; i <= SEQ_CYCLES; i++) begin
			s = idle_stim();
			if (i < SEQ_CYCLES) begin
				s.valid = 1'b1;
				s.addr = {upper_pool[0], 10'(i), 2'b00};
			end
			run_cycle(s);
			// word 0 of each line is its first touch.
			if (i > 0 && inst_hit !== ((i - 1) % 4 != 0)) begin
				report_value("line touch hit", {31'b0, (i - 1) % 4 != 0}, {31'b0, inst_hit});
			end
		end
		finish_test();
	endtask

	task automatic random_test();
		stim_t       s;
		logic [31:0] r;
		start_test("random_alias");
		for (int i = 0; i < RAND_CYCLES; i++) begin
			r = next_rand();
			s = idle_stim();
			s.valid = (r[31:24] < 8'd220);
			s.addr = random_addr();
			run_cycle(s);
		end
		finish_test();
	endtask

	task automatic stall_test();
		stim_t       s;
		logic [31:0] r;
		start_test("stall");
		for (int i = 0; i < STALL_CYCLES; i++) begin
			r = next_rand();
			s = idle_stim();
			s.ready = (r[23:16] >= 8'd64);
			s.valid = (r[31:24] < 8'd230);
			s.addr = random_addr();
			run_cycle(s);
		end
		finish_test();
	endtask

	task automatic flush_test();
		stim_t             s;
		logic [31:0]       r;
		icache_pkg::addr_t a;
		start_test("flush");
		a = random_addr();
		s = idle_stim();
		s.inv = 1'b1;
		run_cycle(s);
		s = idle_stim();
		s.valid = 1'b1;
		s.addr = a;
		s.flush = 1'b1;
		run_cycle(s);
		run_cycle(idle_stim());
		if (inst_valid !== 1'b0) begin
			$display("FAIL %s: inst_valid still high after a flush", test_name);
			test_errors++;
		end
		s.flush = 1'b0;
		run_cycle(s);
		run_cycle(idle_stim());
		if (inst_hit !== 1'b0) begin
			report_value("refetch after flush hit", 32'd0, {31'b0, inst_hit});
		end
		for (int i = 0; i < FLUSH_CYCLES; i++) begin
			r = next_rand();
			s = idle_stim();
			s.flush = (r[23:16] < 8'd26);
			s.valid = (r[31:24] < 8'd230);
			s.addr = random_addr();
			run_cycle(s);
		end
		finish_test();
	endtask

	task automatic reload_test();
		stim_t             s;
		icache_pkg::addr_t warm_addr;
		start_test("reload");
		// cache one line so the invalidate has something to clear.
		warm_addr = random_addr();
		s = idle_stim();
		s.valid = 1'b1;
		s.addr = warm_addr;
		run_cycle(s);
		load_memory();
		s = idle_stim();
		s.inv = 1'b1;
		run_cycle(s);
		for (int i = 0; i < RELOAD_FETCHES; i++) begin
			s = idle_stim();
			s.valid = 1'b1;
			s.addr = (i == 0) ? warm_addr : random_addr();
			run_cycle(s);
			if (i == 1 && inst_hit !== 1'b0) begin
				report_value("first fetch after invalidate hit", 32'd0, {31'b0, inst_hit});
			end
		end
		finish_test();
	endtask

	task automatic reset_test();
		stim_t s;
		start_test("reset");
		apply_reset();
		s = idle_stim();
		repeat (3) run_cycle(s);
		s.valid = 1'b1;
		s.addr = random_addr();
		s.ready = 1'b0;
		repeat (2) run_cycle(s);
		if (inst_valid !== 1'b0) begin
			$display("FAIL %s: inst_valid high before any accepted request", test_name);
			test_errors++;
		end
		s.ready = 1'b1;
		run_cycle(s);
		run_cycle(idle_stim());
		finish_test();
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		rng_state = 32'hd098;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		out_ready = 1'b1;
		invalidate = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		cur = idle_stim();
		cur.rst = 1'b1;
		exp_valid = 1'b0;
		exp_hit = 1'b0;
		exp_inst = '0;
		victim_model = 0;
		clear_valid_model();
		tests_passed = 0;
		tests_failed = 0;
		total_errors = 0;
		for (int i = 0; i < 4; i++) begin
			a = next_rand();
			b = next_rand();
			upper_pool[i] = {a[19:0], b};
		end

		sequential_test();
		random_test();
		stall_test();
		flush_test();
		reload_test();
		reset_test();

		$display("%0d tests passed, %0d tests failed, %0d mismatches",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog.
	initial begin
		#((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- icache_sys.f
+incdir+include
src/icache_pkg.sv
src/way_sram.sv
src/tag_array.sv
src/line_memory.sv
src/fetch_icache.sv
src/icache_top.sv
bench/icache_tb.sv

//--- include/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// cache geometry.
`define ICACHE_SETS 64

// address field boundaries.
// bits 3:2 pick the word, 9:4 the set, 63:10 form the tag.
`define ICACHE_INDEX_LO 4
`define ICACHE_TAG_LO 10

// backing store size in lines.
`define LINE_MEM_DEPTH 256

`endif

//--- src/fetch_icache.sv
`default_nettype none

`include "icache_defs.svh"

module fetch_icache (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        fetch_valid,
	input  icache_pkg::addr_t                fetch_addr,
	input  wire logic                        flush,
	input  wire logic                        out_ready,
	input  icache_pkg::way_vec_t             way_hit,
	input  icache_pkg::line_t [3:0]          way_dout,
	input  icache_pkg::line_t                mem_line,
	output icache_pkg::fill_t                fill,
	output icache_pkg::way_vec_t             way_en,
	output logic                             way_we,
	output icache_pkg::index_t               sram_index,
	output icache_pkg::tag_t                 req_tag,
	output icache_pkg::inst_t                inst,
	output logic                             inst_hit,
	output logic                             inst_valid
);

	localparam int INST_W = $bits(icache_pkg::inst_t);

	icache_pkg::fetch_req_t req;
	icache_pkg::way_vec_t   victim;
	icache_pkg::way_vec_t   hit_q;
	icache_pkg::word_sel_t  word_q;
	icache_pkg::line_t      line_q;
	icache_pkg::line_t      out_line;
	logic                   step;
	logic                   advance;
	logic                   miss;

	assign req.tag = fetch_addr[63:`ICACHE_TAG_LO];
	assign req.index = fetch_addr[`ICACHE_TAG_LO-1:`ICACHE_INDEX_LO];
	assign req.word_sel = fetch_addr[`ICACHE_INDEX_LO-1:2];

	assign sram_index = req.index;
	assign req_tag = req.tag;

	// pipeline moves when the next stage takes data and nothing is flushed.
	assign step = out_ready && !flush;
	assign advance = step && fetch_valid;
	assign miss = (way_hit == '0);

	// hit reads its way, miss writes the victim.
	assign way_en = advance ? (miss ? victim : way_hit) : '0;
	assign way_we = advance && miss;

	assign fill.en = way_we;
	assign fill.way = victim;
	assign fill.tag = req.tag;
	assign fill.index = req.index;

	// round robin over the ways.
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= 4'b0001;
		end else if (step) begin
			victim <= {victim[2:0], victim[3]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= '0;
			inst_valid <= 1'b0;
		end else if (out_ready) begin
			if (flush) begin
				hit_q <= '0;
				inst_valid <= 1'b0;
			end else begin
				hit_q <= fetch_valid ? way_hit : '0;
				inst_valid <= fetch_valid;
			end
		end
	end

	// fill line kept so the miss word comes out one cycle later.
	always_ff @(posedge clk) begin
		if (advance) begin
			word_q <= req.word_sel;
			line_q <= mem_line;
		end
	end

	always_comb begin
		out_line = line_q;
		for (int w = 0; w < 4; w++) begin
			if (hit_q[w]) begin
				out_line = way_dout[w];
			end
		end
	end

	assign inst = out_line[word_q*INST_W +: INST_W];
	assign inst_hit = |hit_q;

	// the output holds while the next stage stalls.
	stall_holds_inst: assert property (
		@(posedge clk) disable iff (rst)
		!out_ready && inst_valid |=> $stable(inst) && inst_valid
	);

	victim_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot(victim)
	);

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

	typedef logic [63:0] addr_t;
	typedef logic [63-`ICACHE_TAG_LO:0] tag_t;
	typedef logic [`ICACHE_TAG_LO-`ICACHE_INDEX_LO-1:0] index_t;
	typedef logic [`ICACHE_INDEX_LO-3:0] word_sel_t;
	typedef logic [127:0] line_t;
	typedef logic [31:0] inst_t;
	typedef logic [3:0] way_vec_t;
	typedef logic [$clog2(`LINE_MEM_DEPTH)-1:0] mem_addr_t;

	// fields in address order, so this is addr[63:2].
	typedef struct packed {
		tag_t      tag;
		index_t    index;
		word_sel_t word_sel;
	} fetch_req_t;

	typedef struct packed {
		logic     en;
		way_vec_t way;
		tag_t     tag;
		index_t   index;
	} fill_t;

endpackage

`default_nettype wire

//--- src/icache_top.sv
`default_nettype none

`include "icache_defs.svh"

module icache_top (
	input  wire logic                               clk,
	input  wire logic                               rst,
	input  wire logic                               fetch_valid,
	input  icache_pkg::addr_t                       fetch_addr,
	input  wire logic                               flush,
	input  wire logic                               out_ready,
	input  wire logic                               invalidate,
	input  wire logic                               load_en,
	input  wire logic [$clog2(`LINE_MEM_DEPTH)+1:0] load_addr,
	input  icache_pkg::inst_t                       load_data,
	output icache_pkg::inst_t                       inst,
	output logic                                    inst_hit,
	output logic                                    inst_valid
);

	icache_pkg::fill_t       fill;
	icache_pkg::way_vec_t    way_en;
	icache_pkg::way_vec_t    way_hit;
	icache_pkg::line_t [3:0] way_dout;
	icache_pkg::line_t       mem_line;
	icache_pkg::index_t      sram_index;
	icache_pkg::tag_t        req_tag;
	logic                    way_we;

	fetch_icache fetch_icache_i (
		.clk        (clk),
		.rst        (rst),
		.fetch_valid(fetch_valid),
		.fetch_addr (fetch_addr),
		.flush      (flush),
		.out_ready  (out_ready),
		.way_hit    (way_hit),
		.way_dout   (way_dout),
		.mem_line   (mem_line),
		.fill       (fill),
		.way_en     (way_en),
		.way_we     (way_we),
		.sram_index (sram_index),
		.req_tag    (req_tag),
		.inst       (inst),
		.inst_hit   (inst_hit),
		.inst_valid (inst_valid)
	);

	tag_array tag_array_i (
		.clk       (clk),
		.rst       (rst),
		.index     (sram_index),
		.tag       (req_tag),
		.fill      (fill),
		.invalidate(invalidate),
		.way_hit   (way_hit)
	);

	genvar g;
	generate
		for (g = 0; g < 4; g++) begin : g_way
			way_sram way_sram_i (
				.clk  (clk),
				.en   (way_en[g]),
				.we   (way_we),
				.index(sram_index),
				.din  (mem_line),
				.dout (way_dout[g])
			);
		end
	endgenerate

	// line address is the eight bits just above the line offset.
	line_memory line_memory_i (
		.clk      (clk),
		.line_addr(fetch_addr[`ICACHE_INDEX_LO +: $bits(icache_pkg::mem_addr_t)]),
		.line     (mem_line),
		.load_en  (load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

//--- src/line_memory.sv
`default_nettype none

`include "icache_defs.svh"

// backing instruction store.
module line_memory (
	input  wire logic                               clk,
	input  icache_pkg::mem_addr_t                   line_addr,
	output icache_pkg::line_t                       line,
	input  wire logic                               load_en,
	input  wire logic [$clog2(`LINE_MEM_DEPTH)+1:0] load_addr,
	input  icache_pkg::inst_t                       load_data
);

	localparam int WORD_W = $bits(icache_pkg::inst_t);
	localparam int WORDS = $bits(icache_pkg::line_t) / WORD_W;

	icache_pkg::inst_t mem [`LINE_MEM_DEPTH][WORDS];

	// low two bits of the word address pick the word in the line.
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr[$clog2(`LINE_MEM_DEPTH)+1:2]][load_addr[1:0]] <= load_data;
		end
	end

	// whole line read with no clock, word 0 in the low bits.
	always_comb begin
		line = '0;
		for (int w = 0; w < WORDS; w++) begin
			line[w*WORD_W +: WORD_W] = mem[line_addr][w];
		end
	end

endmodule

`default_nettype wire

//--- src/tag_array.sv
`default_nettype none

`include "icache_defs.svh"

module tag_array (
	input  wire logic               clk,
	input  wire logic               rst,
	input  icache_pkg::index_t      index,
	input  icache_pkg::tag_t        tag,
	input  icache_pkg::fill_t       fill,
	input  wire logic               invalidate,
	output icache_pkg::way_vec_t    way_hit
);

	localparam int WAYS = $bits(icache_pkg::way_vec_t);

	icache_pkg::tag_t tags [WAYS][`ICACHE_SETS];
	logic [WAYS-1:0][`ICACHE_SETS-1:0] valid;

	// invalidate wins over a fill in the same cycle.
	always_ff @(posedge clk) begin
		if (rst || invalidate) begin
			valid <= '0;
		end else if (fill.en) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill.way[w]) begin
					valid[w][fill.index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill.en) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill.way[w]) begin
					tags[w][fill.index] <= fill.tag;
				end
			end
		end
	end

	// all four ways compared in parallel.
	genvar g;
	generate
		for (g = 0; g < WAYS; g++) begin : g_cmp
			assign way_hit[g] = valid[g][index] && (tags[g][index] == tag);
		end
	endgenerate

	// the core only fills on a miss, so a tag never lives in two ways.
	hit_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(way_hit)
	);

	fill_onehot: assert property (
		@(posedge clk) disable iff (rst)
		fill.en |-> $onehot(fill.way)
	);

endmodule

`default_nettype wire

//--- src/way_sram.sv
`default_nettype none

`include "icache_defs.svh"

// single-port line RAM for one way.
module way_sram (
	input  wire logic               clk,
	input  wire logic               en,
	input  wire logic               we,
	input  icache_pkg::index_t      index,
	input  icache_pkg::line_t       din,
	output icache_pkg::line_t       dout
);

	icache_pkg::line_t mem [`ICACHE_SETS];

	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[index] <= din;
		end
	end

	// write-first; dout only moves on an enabled edge.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				dout <= din;
			end else begin
				dout <= mem[index];
			end
		end
	end

endmodule

`default_nettype wire
